/* Bender.yml */
package:
  name: pit_timer

sources:
  - files:
      - hdl/pit_pkg.sv
      - hdl/pit_ctrl_regs.sv
      - hdl/pit_down_counter.sv
      - hdl/pit_read_latch.sv
      - hdl/pit_channel.sv
      - hdl/pit_timer.sv
  - target: test
    files:
      - test/pit_checker.sv
      - test/pit_tb.sv

/* hdl/pit_channel.sv */
// one timer channel
// register block, down counter and read dispatcher wired together

`timescale 1ns/1ps

module pit_channel (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tick,
    input  logic            cw_wr,      // control word addressed to this channel
    input  logic            load_wr,    // count register write
    input  logic            load_rd,    // count register read
    input  pit_pkg::byte_t  wdata,
    output pit_pkg::byte_t  rd_data,
    output logic            out_pin
);
    import pit_pkg::*;

    mode_t   mode;
    rw_fmt_t rw_fmt;
    count_t  reload;
    count_t  count;
    logic    load_req;
    logic    counting_en;

    // --------------------
    // configuration
    // --------------------
    pit_ctrl_regs i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .cw_wr       (cw_wr),
        .load_wr     (load_wr),
        .wdata       (wdata),
        .mode        (mode),
        .rw_fmt      (rw_fmt),
        .reload      (reload),
        .load_req    (load_req),
        .counting_en (counting_en)
    );

    pit_down_counter i_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .load_req    (load_req),
        .counting_en (counting_en),
        .mode        (mode),
        .reload      (reload),
        .count       (count),
        .out_pin     (out_pin)
    );

    // read side sees the live count
    pit_read_latch i_read (
        .clk     (clk),
        .rst_n   (rst_n),
        .cw_wr   (cw_wr),
        .load_rd (load_rd),
        .wdata   (wdata),
        .rw_fmt  (rw_fmt),
        .count   (count),
        .rd_data (rd_data)
    );

endmodule

/* hdl/pit_ctrl_regs.sv */
// per-channel control word and reload value registers
// assembles the reload value from bus bytes and asks the counter to load it

`timescale 1ns/1ps

module pit_ctrl_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tick,          // counting strobe
    input  logic              cw_wr,         // control word for this channel
    input  logic              load_wr,       // count register write
    input  pit_pkg::byte_t    wdata,
    output pit_pkg::mode_t    mode,
    output pit_pkg::rw_fmt_t  rw_fmt,
    output pit_pkg::count_t   reload,
    output logic              load_req,      // reload value complete, load on next tick
    output logic              counting_en    // counter runs
);
    import pit_pkg::*;

    logic msb_next;     // lsb then msb format, msb byte is next
    logic cw_set;       // control word that is not a latch command
    logic halt_mode;    // modes where an lsb write stops the count

    assign cw_set    = cw_wr && (wdata[5:4] != RW_LATCH);
    assign halt_mode = (mode == MODE_INTR) || (mode == MODE_SWSTROBE);

    // --------------------
    // control word
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode   <= MODE_INTR;
            rw_fmt <= RW_LATCH;    // no load format until programmed
        end else if (cw_set) begin
            mode   <= wdata[3:1];  // bit 0 (bcd) ignored
            rw_fmt <= wdata[5:4];
        end
    end

    // --------------------
    // reload value and load request
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reload      <= '0;
            msb_next    <= 1'b0;
            load_req    <= 1'b0;
            counting_en <= 1'b0;
        end else begin
            // counter takes the reload value on this tick
            if (tick && load_req)
                counting_en <= 1'b1;
            if (tick)
                load_req <= 1'b0;

            // bus writes below override the tick updates
            if (cw_set) begin
                msb_next    <= 1'b0;
                counting_en <= 1'b0;    // wait for a fresh count
            end else if (load_wr) begin
                case (rw_fmt)
                    RW_LSB: begin
                        reload[7:0] <= wdata;
                        load_req    <= 1'b1;
                    end
                    RW_MSB: begin
                        reload[15:8] <= wdata;
                        load_req     <= 1'b1;
                    end
                    RW_BOTH: begin
                        if (msb_next) begin
                            msb_next     <= 1'b0;
                            reload[15:8] <= wdata;
                            // a running rate or square count picks it up at reload
                            load_req     <= ~counting_en;
                        end else begin
                            msb_next    <= 1'b1;
                            reload[7:0] <= wdata;
                            if (halt_mode)
                                counting_en <= 1'b0;    // held until the msb arrives
                        end
                    end
                    default: ;    // latch format is never stored
                endcase
            end
        end
    end

endmodule

/* hdl/pit_down_counter.sv */
// per-channel down counter and output pin
// steps once per tick according to the programmed mode

`timescale 1ns/1ps

module pit_down_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,           // counting strobe
    input  logic             load_req,       // take reload on the next tick
    input  logic             counting_en,
    input  pit_pkg::mode_t   mode,
    input  pit_pkg::count_t  reload,
    output pit_pkg::count_t  count,
    output logic             out_pin
);
    import pit_pkg::*;

    logic   square_mode;    // modes 3 and 7
    logic   rate_mode;      // modes 2 and 6
    logic   autoreload;
    count_t decr;           // step size for this tick
    count_t next_count;

    assign square_mode = (mode == MODE_SQUARE) || (mode == MODE_SQUARE_X);
    assign rate_mode   = (mode == MODE_RATE) || (mode == MODE_RATE_X);
    assign autoreload  = square_mode || rate_mode;

    // --------------------
    // step size
    // --------------------
    // square wave counts by two, an odd value first takes 1 or 3
    // so that the high half is the longer one
    always_comb begin
        if (!square_mode)
            decr = 16'd1;
        else if (!count[0])
            decr = 16'd2;       // even
        else if (out_pin)
            decr = 16'd1;       // odd, high half
        else
            decr = 16'd3;       // odd, low half
    end

    assign next_count = count - decr;

    // --------------------
    // counter
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (tick) begin
            if (load_req)
                count <= reload;                    // first load, every mode
            else if (counting_en) begin
                if (autoreload && (next_count == '0))
                    count <= reload;                // period restarts
                else
                    count <= next_count;            // one shot modes just wrap
            end
        end
    end

    // --------------------
    // output pin
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pin <= 1'b1;
        end else if (tick) begin
            if (load_req) begin
                out_pin <= (mode != MODE_INTR);     // mode 0 drops on load
            end else if (counting_en) begin
                case (mode)
                    MODE_INTR:
                        if (count == '0)
                            out_pin <= 1'b1;        // terminal count
                    MODE_RATE, MODE_RATE_X:
                        // low while the counter reloads
                        out_pin <= (count != 16'd1);
                    MODE_SQUARE, MODE_SQUARE_X:
                        if (count == 16'd2)
                            out_pin <= ~out_pin;    // half period done
                    MODE_SWSTROBE:
                        out_pin <= (count != '0);   // one tick strobe
                    MODE_ONESHOT, MODE_HWSTROBE:
                        out_pin <= 1'b1;            // no gate, pin stays high
                    default:
                        out_pin <= 1'b1;
                endcase
            end
        end
    end

endmodule

/* hdl/pit_pkg.sv */
// shared widths, bus constants and mode codes of the interval timer
// imported by every timer module

package pit_pkg;

    // --------------------
    // data widths
    // --------------------
    typedef logic [7:0]  byte_t;     // one bus data byte
    typedef logic [15:0] count_t;    // count, reload or latched value
    typedef logic [1:0]  rw_fmt_t;   // read/load format field, cw bits 5:4
    typedef logic [2:0]  mode_t;     // counting mode field, cw bits 3:1

    // --------------------
    // bus map
    // --------------------
    localparam logic [1:0] ADDR_CTRL = 2'd3;    // control word address
    localparam int NUM_CHANNELS      = 3;

    // read/load formats
    localparam rw_fmt_t RW_LATCH = 2'd0;    // counter latch command
    localparam rw_fmt_t RW_LSB   = 2'd1;    // lsb only
    localparam rw_fmt_t RW_MSB   = 2'd2;    // msb only
    localparam rw_fmt_t RW_BOTH  = 2'd3;    // lsb then msb

    // --------------------
    // counting modes
    // --------------------
    localparam mode_t MODE_INTR     = 3'd0;    // interrupt on terminal count
    localparam mode_t MODE_ONESHOT  = 3'd1;    // no gate here, counts once
    localparam mode_t MODE_RATE     = 3'd2;    // rate generator
    localparam mode_t MODE_SQUARE   = 3'd3;    // square wave
    localparam mode_t MODE_SWSTROBE = 3'd4;    // software strobe
    localparam mode_t MODE_HWSTROBE = 3'd5;    // no gate here, counts once
    localparam mode_t MODE_RATE_X   = 3'd6;    // alias of rate generator
    localparam mode_t MODE_SQUARE_X = 3'd7;    // alias of square wave

    // read dispatcher state
    // latch first -> latch last -> live, one step per read
    typedef enum logic [1:0] {
        READ_LIVE        = 2'd0,    // reads follow the running count
        READ_LATCH_LAST  = 2'd1,    // one latched byte left
        READ_LATCH_FIRST = 2'd2     // latch just taken, two bytes left
    } read_state_e;

endpackage

/* hdl/pit_read_latch.sv */
// per-channel read dispatcher
// holds the latched count and picks the byte returned on each read

`timescale 1ns/1ps

module pit_read_latch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cw_wr,      // control word for this channel
    input  logic              load_rd,    // count register read
    input  pit_pkg::byte_t    wdata,
    input  pit_pkg::rw_fmt_t  rw_fmt,
    input  pit_pkg::count_t   count,
    output pit_pkg::byte_t    rd_data
);
    import pit_pkg::*;

    read_state_e read_state;
    count_t      latched;
    count_t      src;         // value the next read comes from
    logic        read_msb;    // lsb then msb format, msb is next
    logic        latch_cmd;

    assign latch_cmd = (wdata[5:4] == RW_LATCH);
    assign src       = (read_state == READ_LIVE) ? count : latched;

    // byte mapping per format
    always_comb begin
        case (rw_fmt)
            RW_LSB:  rd_data = src[7:0];
            RW_MSB:  rd_data = src[15:8];
            default: rd_data = read_msb ? src[15:8] : src[7:0];
        endcase
    end

    // --------------------
    // latch and read order
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_state <= READ_LIVE;
            latched    <= '0;
            read_msb   <= 1'b0;
        end else if (cw_wr) begin
            read_msb <= 1'b0;                  // any control word restarts at lsb
            if (latch_cmd) begin
                latched    <= count;           // freeze the current count
                read_state <= READ_LATCH_FIRST;
            end else begin
                read_state <= READ_LIVE;
            end
        end else if (load_rd) begin
            read_msb <= ~read_msb;
            case (read_state)
                READ_LATCH_FIRST: read_state <= READ_LATCH_LAST;
                default:          read_state <= READ_LIVE;    // latch used up
            endcase
        end
    end

endmodule

/* hdl/pit_timer.sv */
// three channel programmable interval timer, 8253 style
// byte-wide bus, addresses 0..2 are the counters, 3 takes control words

`timescale 1ns/1ps

module pit_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tick,     // one cycle counting strobe
    input  logic            cs,
    input  logic            rd,
    input  logic            wr,
    input  logic [1:0]      addr,
    input  pit_pkg::byte_t  wdata,
    output pit_pkg::byte_t  rdata,
    output logic            out0,
    output logic            out1,
    output logic            out2
);
    import pit_pkg::*;

    logic [NUM_CHANNELS-1:0] load_wr;
    logic [NUM_CHANNELS-1:0] load_rd;
    logic [NUM_CHANNELS-1:0] cw_wr;
    logic [NUM_CHANNELS-1:0] ch_out;
    byte_t                   ch_rd_data [NUM_CHANNELS];

    // --------------------
    // address decode
    // --------------------
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            load_wr[i] = cs && wr && (addr == 2'(i));
            load_rd[i] = cs && rd && (addr == 2'(i));
            // select 3 matches no channel
            cw_wr[i]   = cs && wr && (addr == ADDR_CTRL) && (wdata[7:6] == 2'(i));
        end
    end

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_ch
        pit_channel i_channel (
            .clk     (clk),
            .rst_n   (rst_n),
            .tick    (tick),
            .cw_wr   (cw_wr[g]),
            .load_wr (load_wr[g]),
            .load_rd (load_rd[g]),
            .wdata   (wdata),
            .rd_data (ch_rd_data[g]),
            .out_pin (ch_out[g])
        );
    end

    // read data of the addressed channel, zero otherwise
    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (load_rd[i])
                rdata = ch_rd_data[i];
        end
    end

    assign out0 = ch_out[0];
    assign out1 = ch_out[1];
    assign out2 = ch_out[2];

endmodule

/* pit_timer.f */
hdl/pit_pkg.sv
hdl/pit_ctrl_regs.sv
hdl/pit_down_counter.sv
hdl/pit_read_latch.sv
hdl/pit_channel.sv
hdl/pit_timer.sv
test/pit_checker.sv
test/pit_tb.sv

/* test/pit_checker.sv */
// watches the timer ports and keeps a reference model of each channel
// compares rdata on every bus cycle and the output pins on every clock

`timescale 1ns/1ps

module pit_checker (
    input logic            clk,
    input logic            rst_n,
    input logic            tick,
    input logic            cs,
    input logic            rd,
    input logic            wr,
    input logic [1:0]      addr,
    input pit_pkg::byte_t  wdata,
    input pit_pkg::byte_t  rdata,
    input logic            out0,
    input logic            out1,
    input logic            out2
);
    import pit_pkg::*;

    int errors = 0;
    int checks = 0;

    // model state per channel
    mode_t       m_mode     [NUM_CHANNELS];
    rw_fmt_t     m_fmt      [NUM_CHANNELS];
    count_t      m_reload   [NUM_CHANNELS];
    count_t      m_count    [NUM_CHANNELS];
    count_t      m_latched  [NUM_CHANNELS];
    logic        m_msb_next [NUM_CHANNELS];   // next count byte written is the msb
    logic        m_load_req [NUM_CHANNELS];
    logic        m_run      [NUM_CHANNELS];
    logic        m_out      [NUM_CHANNELS];
    logic        m_read_msb [NUM_CHANNELS];
    read_state_e m_rstate   [NUM_CHANNELS];

    // --------------------
    // reference functions
    // --------------------
    // one counting tick; rate and square reload instead of reaching 0
    function automatic count_t step_count(mode_t mode, count_t cnt, count_t rel, logic pin);
        count_t step;
        count_t nxt;
        step = 16'd1;
        if (mode == 3'd3 || mode == 3'd7)
            step = !cnt[0] ? 16'd2 : (pin ? 16'd1 : 16'd3);    // odd: longer high half
        nxt = cnt - step;
        if ((mode == 3'd2 || mode == 3'd3 || mode == 3'd6 || mode == 3'd7) && nxt == 16'd0)
            return rel;
        return nxt;
    endfunction

    function automatic logic step_out(mode_t mode, count_t cnt, logic pin);
        case (mode)
            3'd0:       return (cnt == 16'd0) ? 1'b1 : pin;    // terminal count
            3'd2, 3'd6: return cnt != 16'd1;
            3'd3, 3'd7: return (cnt == 16'd2) ? ~pin : pin;
            3'd4:       return cnt != 16'd0;
            default:    return 1'b1;
        endcase
    endfunction

    function automatic byte_t read_byte(rw_fmt_t fmt, count_t src, logic msb);
        if (fmt == 2'd1)
            return src[7:0];
        if (fmt == 2'd2)
            return src[15:8];
        return msb ? src[15:8] : src[7:0];
    endfunction

    function automatic byte_t expected_rdata();
        count_t src;
        if (!(cs && rd) || addr == ADDR_CTRL)
            return 8'h00;
        src = (m_rstate[addr] == READ_LIVE) ? m_count[addr] : m_latched[addr];
        return read_byte(m_fmt[addr], src, m_read_msb[addr]);
    endfunction

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // --------------------
    // model update for one clock edge
    // --------------------
    task automatic model_edge(input int ch);
        logic   cw;
        logic   lw;
        logic   lr;
        logic   old_run;
        logic   old_req;
        count_t cnt_n;
        logic   out_n;
        cw = cs && wr && addr == ADDR_CTRL && wdata[7:6] == 2'(ch);
        lw = cs && wr && addr == 2'(ch);
        lr = cs && rd && addr == 2'(ch);
        old_run = m_run[ch];
        old_req = m_load_req[ch];
        cnt_n = m_count[ch];
        out_n = m_out[ch];

        // counter and pin, from the state before the edge
        if (tick && old_req) begin
            cnt_n = m_reload[ch];
            out_n = (m_mode[ch] != 3'd0);
        end else if (tick && old_run) begin
            cnt_n = step_count(m_mode[ch], m_count[ch], m_reload[ch], m_out[ch]);
            out_n = step_out(m_mode[ch], m_count[ch], m_out[ch]);
        end

        // read side
        if (cw) begin
            m_read_msb[ch] = 1'b0;
            if (wdata[5:4] == 2'd0) begin
                m_latched[ch] = m_count[ch];
                m_rstate[ch]  = READ_LATCH_FIRST;
            end else
                m_rstate[ch]  = READ_LIVE;
        end else if (lr) begin
            m_read_msb[ch] = ~m_read_msb[ch];
            m_rstate[ch] = (m_rstate[ch] == READ_LATCH_FIRST) ? READ_LATCH_LAST : READ_LIVE;
        end

        // registers; bus writes win over the tick
        if (tick && old_req)
            m_run[ch] = 1'b1;
        if (tick)
            m_load_req[ch] = 1'b0;
        if (cw && wdata[5:4] != 2'd0) begin
            m_mode[ch]     = wdata[3:1];
            m_fmt[ch]      = wdata[5:4];
            m_msb_next[ch] = 1'b0;
            m_run[ch]      = 1'b0;
        end else if (lw && m_fmt[ch] == 2'd1) begin
            m_reload[ch][7:0] = wdata;
            m_load_req[ch]    = 1'b1;
        end else if (lw && m_fmt[ch] == 2'd2) begin
            m_reload[ch][15:8] = wdata;
            m_load_req[ch]     = 1'b1;
        end else if (lw && m_fmt[ch] == 2'd3) begin
            if (m_msb_next[ch]) begin
                m_reload[ch][15:8] = wdata;
                m_load_req[ch]     = ~old_run;    // running count takes it at reload
            end else begin
                m_reload[ch][7:0] = wdata;
                if (m_mode[ch] == 3'd0 || m_mode[ch] == 3'd4)
                    m_run[ch] = 1'b0;
            end
            m_msb_next[ch] = ~m_msb_next[ch];
        end
        m_count[ch] = cnt_n;
        m_out[ch]   = out_n;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                m_mode[ch] = '0;
                m_fmt[ch] = '0;
                m_reload[ch] = '0;
                m_count[ch] = '0;
                m_latched[ch] = '0;
                m_msb_next[ch] = 1'b0;
                m_load_req[ch] = 1'b0;
                m_run[ch] = 1'b0;
                m_out[ch] = 1'b1;
                m_read_msb[ch] = 1'b0;
                m_rstate[ch] = READ_LIVE;
            end
        end else begin
            compare("rdata", rdata, expected_rdata());
            compare("out0", out0, m_out[0]);
            compare("out1", out1, m_out[1]);
            compare("out2", out2, m_out[2]);
            for (int ch = 0; ch < NUM_CHANNELS; ch++)
                model_edge(ch);
        end
    end

endmodule

/* test/pit_tb.sv */
// testbench top for the interval timer
// drives the bus and the tick strobe on falling edges
// pit_checker does the comparing

`timescale 1ns/1ps

module pit_tb;
    import pit_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        tick;
    logic        cs;
    logic        rd;
    logic        wr;
    logic [1:0]  addr;
    byte_t       wdata;
    byte_t       rdata;
    logic        out0;
    logic        out1;
    logic        out2;

    logic        tick_en;       // tick generator running
    logic        tick_rand;     // random gaps instead of every 4 clocks
    int          gap;
    int          tick_count;    // ticks seen at rising edges
    int          tb_errs;       // direct checks and timeouts
    int          err_mark;
    int          tests;
    int          failed_tests;
    int          t0;
    int          sel;
    int          rch;

    pit_timer i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .cs    (cs),
        .rd    (rd),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .out0  (out0),
        .out1  (out1),
        .out2  (out2)
    );

    pit_checker i_chk (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;    // 40 ns period

    // --------------------
    // tick strobe
    // --------------------
    always @(negedge clk) begin
        if (!tick_en) begin
            tick <= 1'b0;
            gap  = 0;
        end else if (gap == 0) begin
            tick <= 1'b1;
            gap  = tick_rand ? ($urandom % 6) + 1 : 3;    // 3 idle clocks give every 4 clocks
        end else begin
            tick <= 1'b0;
            gap--;
        end
    end

    always @(posedge clk)
        if (tick)
            tick_count++;

    function automatic logic out_of(input int ch);
        case (ch)
            0:       return out0;
            1:       return out1;
            default: return out2;
        endcase
    endfunction

    // --------------------
    // bus and wait tasks
    // --------------------
    task automatic bus_write(input logic [1:0] a, input byte_t d);
        @(negedge clk);
        cs    = 1'b1;
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        cs    = 1'b0;
        wr    = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a);
        @(negedge clk);
        cs   = 1'b1;
        rd   = 1'b1;
        addr = a;             // rdata checked by pit_checker at the rising edge
        @(negedge clk);
        cs   = 1'b0;
        rd   = 1'b0;
    endtask

    // control word followed by the count bytes the format asks for
    task automatic program_ch(input int ch, input int mode, input int fmt, input int value);
        bus_write(ADDR_CTRL, {ch[1:0], fmt[1:0], mode[2:0], 1'b0});
        if (ch == 3)
            return;           // select 3 reaches no channel
        if (fmt == 1 || fmt == 3)
            bus_write(ch[1:0], value[7:0]);
        if (fmt == 2 || fmt == 3)
            bus_write(ch[1:0], value[15:8]);
    endtask

    task automatic wait_ticks(input int n);
        int seen;
        int cyc;
        seen = 0;
        cyc  = 0;
        while (seen < n && cyc < 10 * n + 20) begin
            @(posedge clk);
            cyc++;
            if (tick)
                seen++;
        end
        if (seen < n) begin
            $display("timeout: only %0d of %0d ticks arrived", seen, n);
            tb_errs++;
        end
    endtask

    task automatic wait_out(input int ch, input logic level, input int max_cycles);
        int cyc;
        cyc = 0;
        while (out_of(ch) !== level && cyc < max_cycles) begin
            @(negedge clk);
            cyc++;
        end
        if (out_of(ch) !== level) begin
            $display("timeout: out%0d did not go to %0b within %0d cycles", ch, level, max_cycles);
            tb_errs++;
        end
    endtask

    task automatic expect_ticks(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            tb_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        int now_errs;
        now_errs = i_chk.errors + tb_errs;
        tests++;
        if (now_errs == err_mark) begin
            $display("[%s] passed", name);
        end else begin
            failed_tests++;
            $display("[%s] failed with %0d errors", name, now_errs - err_mark);
        end
        err_mark = now_errs;
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        void'($urandom(32'hebc3_d79a));
        rst_n = 1'b0;
        tick  = 1'b0;
        cs    = 1'b0;
        rd    = 1'b0;
        wr    = 1'b0;
        addr  = 2'd0;
        wdata = '0;
        tick_en = 1'b0;
        tick_rand = 1'b0;
        tick_count = 0;
        tb_errs = 0;
        err_mark = 0;
        tests = 0;
        failed_tests = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // outputs high after reset and reads return 0
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            bus_read(ch[1:0]);
        finish_test("reset");
        tick_en = 1'b1;

        // mode 0 with N = 10 goes low on the load tick and high at tick N+2
        program_ch(0, 0, 3, 10);
        t0 = tick_count;
        wait_out(0, 1'b0, 40);
        expect_ticks("out0 ticks to low", tick_count - t0, 1);
        bus_read(0);
        bus_read(0);
        wait_out(0, 1'b1, 80);
        expect_ticks("out0 ticks to high", tick_count - t0, 12);
        finish_test("mode 0");

        // rate on ch1 and square on ch2 followed by the mode 2 alias
        program_ch(1, 2, 3, 5);
        program_ch(2, 3, 3, 6);
        wait_ticks(24);
        bus_read(1);
        bus_read(1);
        program_ch(1, 6, 1, 4);
        wait_ticks(16);
        finish_test("modes 2/3/6");

        // mode 4 strobe is one tick wide
        program_ch(0, 4, 3, 7);
        wait_out(0, 1'b0, 80);
        t0 = tick_count;
        wait_out(0, 1'b1, 20);
        expect_ticks("out0 strobe width", tick_count - t0, 1);
        wait_ticks(10);
        finish_test("mode 4");

        // latch while ch1 keeps counting
        program_ch(1, 2, 3, 16'h0123);
        wait_ticks(3);
        bus_write(ADDR_CTRL, 8'h40);    // ch1 latch command
        wait_ticks(2);
        repeat (3) bus_read(1);
        program_ch(2, 3, 1, 16'h0040);
        wait_ticks(3);
        repeat (2) bus_read(2);
        program_ch(2, 2, 2, 16'h0300);
        wait_ticks(3);
        repeat (2) bus_read(2);
        finish_test("latch/read");

        // a select 3 word leaves every channel running
        program_ch(3, 0, 3, 0);
        wait_ticks(2);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            bus_read(ch[1:0]);

        // random words to random channels with random tick gaps
        tick_rand = 1'b1;
        repeat (24) begin
            sel = $urandom % 4;
            program_ch(sel, $urandom % 8, ($urandom % 3) + 1, ($urandom % 40) + 1);
            wait_ticks(($urandom % 8) + 1);
            rch = $urandom % 3;
            if ($urandom % 2)
                bus_write(ADDR_CTRL, {rch[1:0], 6'b0});
            bus_read(rch[1:0]);
            bus_read(rch[1:0]);
        end
        finish_test("channel select");

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, other errors %0d",
                 tests, failed_tests, i_chk.checks, i_chk.errors, tb_errs);
        if (i_chk.errors + tb_errs == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
